//--- rp_router_top.f
hw/router_pkg.sv
hw/signal_select.sv
hw/slow_dac_scale.sv
hw/trigger_detect.sv
hw/router_regs.sv
hw/rp_router_top.sv
sim/router_regs_chk.sv
sim/rp_router_tb.sv

//--- Makefile
# Verilator build and run of the signal router testbench

VERILATOR ?= verilator
TOP       ?= rp_router_tb
FILELIST  ?= rp_router_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- sim/rp_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rp_router_tb;
    import router_pkg::*;

    localparam int ACK_TIMEOUT = 16;    // cycles per bus access
    localparam int SETTLE      = 5;     // slow path needs 3

    logic                  clk = 1'b0;
    logic                  rst;
    sample_t               in1;
    sample_t               in2;
    logic                  ext_trig;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_ADR_W-1:0]   wb_adr;
    logic [WB_DAT_W-1:0]   wb_wdat;
    logic [WB_DAT_W-1:0]   wb_rdat;
    logic                  wb_ack;
    sample_t               out1;
    sample_t               out2;
    sample_t               osc1;
    sample_t               osc2;
    logic [SLOW_W-1:0]     slow3;
    logic [SLOW_W-1:0]     slow4;
    logic                  trig;
    logic [OSC_CTRL_W-1:0] osc_ctrl;

    route_cfg_t exp_cfg;            // last config written by the host
    logic       check_en  = 1'b0;   // high once the outputs have settled
    int         pulse_cnt = 0;

    // config register addresses with their field widths and reset values
    logic [WB_ADR_W-1:0] cfg_adr [8] = '{ADR_SCOPE_A, ADR_SCOPE_B, ADR_OSC_CTRL, ADR_TRIG,
                                         ADR_OUT1_SEL, ADR_OUT2_SEL, ADR_SLOW3_SEL,
                                         ADR_SLOW4_SEL};
    int                  cfg_w   [8] = '{5, 5, 2, 3, 4, 4, 4, 4};
    int                  cfg_rst [8] = '{1, 2, 3, 0, 0, 0, 0, 0};
    // read only then unmapped
    logic [WB_ADR_W-1:0] ro_adr [11] = '{ADR_IN1, ADR_IN2, ADR_OUT1, ADR_OUT2, ADR_SLOW3,
                                         ADR_SLOW4, ADR_OSCA, ADR_OSCB, 8'h18, 8'h38, 8'hFC};
    int                  sel_list [4] = '{0, 1, 2, 5};

    always #10 clk = ~clk;  // 20 ns period

    rp_router_top rp_router_top_inst (
        .clk           (clk),
        .rst           (rst),
        .i_in1         (in1),
        .i_in2         (in2),
        .i_ext_trigger (ext_trig),
        .i_wb_cyc      (wb_cyc),
        .i_wb_stb      (wb_stb),
        .i_wb_we       (wb_we),
        .i_wb_adr      (wb_adr),
        .i_wb_dat      (wb_wdat),
        .o_wb_dat      (wb_rdat),
        .o_wb_ack      (wb_ack),
        .o_out1        (out1),
        .o_out2        (out2),
        .o_osc1        (osc1),
        .o_osc2        (osc2),
        .o_slow3       (slow3),
        .o_slow4       (slow4),
        .o_trigger     (trig),
        .o_osc_ctrl    (osc_ctrl)
    );

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    // index 1 is in1, index 2 is in2, everything else zero
    function automatic sample_t route_ref(input int sel, input sample_t a, input sample_t b);
        if (sel == 1) return a;
        if (sel == 2) return b;
        return '0;
    endfunction

    // index 0 is midscale-low, then +8192, *156, keep bits 21..10
    function automatic logic [SLOW_W-1:0] slow_ref(input int sel, input sample_t a,
                                                   input sample_t b);
        int x;
        x = (sel == 0) ? -8192 : int'(route_ref(sel, a, b));
        return SLOW_W'(((x + 8192) * 156) >>> 10);
    endfunction

    task automatic stop_failed(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_failed($sformatf("** Error at time %0t: %s is %h, expected %h",
                                  $time, what, got, exp));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // ----------------------------------------------------------------------
    // wishbone host tasks start and end on a falling edge
    // ----------------------------------------------------------------------
    task automatic wait_ack(input string what);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < ACK_TIMEOUT);
        if (!wb_ack) begin
            stop_failed($sformatf("bus %s to address %h was never acked", what, wb_adr));
        end
    endtask

    task automatic bus_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] dat);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = 1'b1;
        wb_adr  = adr;
        wb_wdat = dat;
        wait_ack("write");
        wb_cyc  = 1'b0;     // drop after ack
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
    endtask

    task automatic bus_read(input logic [WB_ADR_W-1:0] adr, output logic [31:0] dat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack("read");
        dat    = wb_rdat;   // valid with ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic apply_cfg(input route_cfg_t c);
        bus_write(ADR_SCOPE_A,   32'(c.scope_a_sel));
        bus_write(ADR_SCOPE_B,   32'(c.scope_b_sel));
        bus_write(ADR_OSC_CTRL,  32'(c.osc_ctrl));
        bus_write(ADR_TRIG,      32'(c.trig_sel));
        bus_write(ADR_OUT1_SEL,  32'(c.out1_sel));
        bus_write(ADR_OUT2_SEL,  32'(c.out2_sel));
        bus_write(ADR_SLOW3_SEL, 32'(c.slow3_sel));
        bus_write(ADR_SLOW4_SEL, 32'(c.slow4_sel));
        exp_cfg = c;
    endtask

    // let the pipes settle, then the comparing process runs n cycles
    task automatic run_checks(input int n);
        wait_cycles(SETTLE);
        check_en = 1'b1;
        wait_cycles(n);
        check_en = 1'b0;
    endtask

    task automatic check_status();
        logic [WB_DAT_W-1:0] rd;
        bus_read(ADR_IN1, rd);
        compare("in1 readback", rd, 32'(in1));
        bus_read(ADR_IN2, rd);
        compare("in2 readback", rd, 32'(in2));
        bus_read(ADR_OUT1, rd);
        compare("out1 readback", rd, 32'(route_ref(int'(exp_cfg.out1_sel), in1, in2)));
        bus_read(ADR_OUT2, rd);
        compare("out2 readback", rd, 32'(route_ref(int'(exp_cfg.out2_sel), in1, in2)));
        bus_read(ADR_OSCA, rd);
        compare("osc a readback", rd, 32'(route_ref(int'(exp_cfg.scope_a_sel), in1, in2)));
        bus_read(ADR_OSCB, rd);
        compare("osc b readback", rd, 32'(route_ref(int'(exp_cfg.scope_b_sel), in1, in2)));
        bus_read(ADR_SLOW3, rd);
        compare("slow3 readback", rd, 32'(slow_ref(int'(exp_cfg.slow3_sel), in1, in2)));
        bus_read(ADR_SLOW4, rd);
        compare("slow4 readback", rd, 32'(slow_ref(int'(exp_cfg.slow4_sel), in1, in2)));
    endtask

    // rising edges at least 3 cycles apart
    task automatic pulse_trigger(input int n);
        repeat (n) begin
            ext_trig = 1'b1;
            wait_cycles(1 + $urandom_range(0, 2));
            ext_trig = 1'b0;
            wait_cycles(2 + $urandom_range(0, 2));
        end
        wait_cycles(4);     // last tick lands 2 cycles late
    endtask

    // ----------------------------------------------------------------------
    // comparing process sees pre-edge values at posedge
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (check_en) begin
            compare("osc1", 32'(osc1), 32'(route_ref(int'(exp_cfg.scope_a_sel), in1, in2)));
            compare("osc2", 32'(osc2), 32'(route_ref(int'(exp_cfg.scope_b_sel), in1, in2)));
            compare("out1", 32'(out1), 32'(route_ref(int'(exp_cfg.out1_sel), in1, in2)));
            compare("out2", 32'(out2), 32'(route_ref(int'(exp_cfg.out2_sel), in1, in2)));
            compare("slow3", 32'(slow3), 32'(slow_ref(int'(exp_cfg.slow3_sel), in1, in2)));
            compare("slow4", 32'(slow4), 32'(slow_ref(int'(exp_cfg.slow4_sel), in1, in2)));
            compare("osc_ctrl", 32'(osc_ctrl), 32'(exp_cfg.osc_ctrl));
        end
    end

    always @(posedge clk) begin
        if (trig) pulse_cnt <= pulse_cnt + 1;   // one count per tick
    end

    initial begin
        route_cfg_t          c;
        logic [WB_DAT_W-1:0] rd;
        logic [WB_DAT_W-1:0] v;
        logic [WB_DAT_W-1:0] saved [8];
        int                  base;

        void'($urandom(58));
        rst      = 1'b1;
        in1      = sample_t'(14'h0155);   // nonzero, scope a/b pick these after reset
        in2      = sample_t'(14'h2AAA);
        ext_trig = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdat  = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // after reset
        compare("ack after reset", 32'(wb_ack), 32'd0);
        compare("trigger after reset", 32'(trig), 32'd0);
        compare("osc1 after reset", 32'(osc1), 32'd0);
        compare("osc2 after reset", 32'(osc2), 32'd0);
        compare("slow3 after reset", 32'(slow3), 32'd0);
        compare("osc_ctrl after reset", 32'(osc_ctrl), 32'd3);
        foreach (cfg_adr[i]) begin
            bus_read(cfg_adr[i], rd);
            compare($sformatf("reset value of reg %h", cfg_adr[i]), rd, 32'(cfg_rst[i]));
        end

        // masked writes then ignored writes to read only and unmapped addresses
        foreach (cfg_adr[i]) begin
            v = $urandom;
            bus_write(cfg_adr[i], v);
            bus_read(cfg_adr[i], rd);
            compare($sformatf("reg %h readback", cfg_adr[i]), rd,
                    v & ((32'd1 << cfg_w[i]) - 32'd1));
            saved[i] = rd;
        end
        foreach (ro_adr[i]) begin
            bus_write(ro_adr[i], $urandom);
        end
        foreach (cfg_adr[i]) begin
            bus_read(cfg_adr[i], rd);
            compare($sformatf("reg %h after ignored writes", cfg_adr[i]), rd, saved[i]);
        end
        for (int i = 8; i < 11; i++) begin
            bus_read(ro_adr[i], rd);
            compare($sformatf("unmapped read %h", ro_adr[i]), rd, 32'd0);
        end

        // every select of scope and fast outputs
        for (int s = 0; s < SCOPE_SRC_N; s++) begin
            in1           = sample_t'($urandom);
            in2           = sample_t'($urandom);
            c.scope_a_sel = 5'(s);
            c.scope_b_sel = 5'(31 - s);
            c.out1_sel    = 4'(s);
            c.out2_sel    = 4'(15 - s);
            c.osc_ctrl    = 2'($urandom);
            c.trig_sel    = 3'($urandom);
            c.slow3_sel   = 4'($urandom);
            c.slow4_sel   = 4'($urandom);
            apply_cfg(c);
            run_checks(4);
            check_status();
        end

        // slow dacs
        foreach (sel_list[i]) begin
            c           = exp_cfg;
            c.slow3_sel = 4'(sel_list[i]);
            c.slow4_sel = 4'(sel_list[3 - i]);
            apply_cfg(c);
            repeat (3) begin
                in1 = sample_t'($urandom);
                in2 = sample_t'($urandom);
                run_checks(3);
                check_status();
                if (sel_list[i] == 0) compare("slow3 midscale-low", 32'(slow3), 32'd0);
            end
        end

        // trigger ticks
        c          = exp_cfg;
        c.trig_sel = 3'd0;
        apply_cfg(c);
        wait_cycles(SETTLE);
        base = pulse_cnt;
        pulse_trigger(12);
        compare("tick count with trig_sel 0", 32'(pulse_cnt - base), 32'd12);
        c.trig_sel = 3'd1;
        apply_cfg(c);
        wait_cycles(SETTLE);
        base = pulse_cnt;
        pulse_trigger(12);
        compare("tick count with trig_sel 1", 32'(pulse_cnt - base), 32'd0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/router_regs_chk.sv
`timescale 1ns/1ps
`default_nettype none

// bus and trigger protocol checks, bound into the design
module router_regs_chk (
    input wire clk,
    input wire rst,
    input wire i_req,       // cyc & stb
    input wire i_ack,
    input wire i_tick       // trigger pulse
);

    // ack is a one cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (rst) i_ack |=> !i_ack)
        else $error("wishbone ack high two cycles running");

    // ack only after a sampled request
    ack_after_req: assert property (@(posedge clk) disable iff (rst) i_ack |-> $past(i_req))
        else $error("wishbone ack without a request");

    // pending request gets its ack next cycle
    req_gets_ack: assert property (@(posedge clk) disable iff (rst) (i_req && !i_ack) |=> i_ack)
        else $error("wishbone request not acked");

    tick_single: assert property (@(posedge clk) disable iff (rst) i_tick |=> !i_tick)
        else $error("trigger tick longer than one cycle");

endmodule

// ----------------------------------------------------------------------
// attach to the register block and the trigger detector
// ----------------------------------------------------------------------
bind router_regs router_regs_chk regs_chk_inst (
    .clk    (clk),
    .rst    (rst),
    .i_req  (i_wb_cyc & i_wb_stb),
    .i_ack  (o_wb_ack),
    .i_tick (1'b0)
);

bind trigger_detect router_regs_chk trig_chk_inst (
    .clk    (clk),
    .rst    (rst),
    .i_req  (1'b0),
    .i_ack  (1'b0),
    .i_tick (o_trigger)
);

`default_nettype wire

//--- hw/rp_router_top.sv
`timescale 1ns/1ps
`default_nettype none

// adc/dac signal router, host set up over wishbone
module rp_router_top (
    input  wire                              clk,
    input  wire                              rst,
    input  wire router_pkg::sample_t         i_in1,
    input  wire router_pkg::sample_t         i_in2,
    input  wire                              i_ext_trigger,
    input  wire                              i_wb_cyc,
    input  wire                              i_wb_stb,
    input  wire                              i_wb_we,
    input  wire [router_pkg::WB_ADR_W-1:0]   i_wb_adr,
    input  wire [router_pkg::WB_DAT_W-1:0]   i_wb_dat,
    output logic [router_pkg::WB_DAT_W-1:0]  o_wb_dat,
    output logic                             o_wb_ack,
    output router_pkg::sample_t              o_out1,
    output router_pkg::sample_t              o_out2,
    output router_pkg::sample_t              o_osc1,
    output router_pkg::sample_t              o_osc2,
    output logic [router_pkg::SLOW_W-1:0]    o_slow3,
    output logic [router_pkg::SLOW_W-1:0]    o_slow4,
    output logic                             o_trigger,
    output logic [router_pkg::OSC_CTRL_W-1:0] o_osc_ctrl
);
    import router_pkg::*;

    route_cfg_t    cfg;
    route_status_t status;
    sample_t       scope_src [SCOPE_SRC_N];
    sample_t       out_src   [OUT_SRC_N];
    sample_t       slow_src  [OUT_SRC_N];
    sample_t       slow3_smp;   // selected, before scaling
    sample_t       slow4_smp;

    // ----------------------------------------------------------------------
    // source arrays, only in1 / in2 live
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < SCOPE_SRC_N; i++) begin
            scope_src[i] = '0;
        end
        for (int i = 0; i < OUT_SRC_N; i++) begin
            out_src[i]  = '0;
            slow_src[i] = '0;
        end
        scope_src[SRC_IN1] = i_in1;
        scope_src[SRC_IN2] = i_in2;
        out_src[SRC_IN1]   = i_in1;
        out_src[SRC_IN2]   = i_in2;
        slow_src[SRC_MID]  = SLOW_MID_LOW;  // gives code 0
        slow_src[SRC_IN1]  = i_in1;
        slow_src[SRC_IN2]  = i_in2;
    end

    router_regs regs_inst (
        .clk      (clk),
        .rst      (rst),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_status (status),
        .o_cfg    (cfg)
    );

    // scope channels
    signal_select #(.payload_t(sample_t), .SRC_N(SCOPE_SRC_N), .SEL_W(SCOPE_SEL_W))
        scope_a_inst (.clk(clk), .rst(rst), .i_src(scope_src), .i_sel(cfg.scope_a_sel),
                      .o_out(o_osc1));
    signal_select #(.payload_t(sample_t), .SRC_N(SCOPE_SRC_N), .SEL_W(SCOPE_SEL_W))
        scope_b_inst (.clk(clk), .rst(rst), .i_src(scope_src), .i_sel(cfg.scope_b_sel),
                      .o_out(o_osc2));

    // fast dac outputs
    signal_select #(.payload_t(sample_t), .SRC_N(OUT_SRC_N), .SEL_W(OUT_SEL_W))
        out1_inst (.clk(clk), .rst(rst), .i_src(out_src), .i_sel(cfg.out1_sel),
                   .o_out(o_out1));
    signal_select #(.payload_t(sample_t), .SRC_N(OUT_SRC_N), .SEL_W(OUT_SEL_W))
        out2_inst (.clk(clk), .rst(rst), .i_src(out_src), .i_sel(cfg.out2_sel),
                   .o_out(o_out2));

    // ----------------------------------------------------------------------
    // slow dacs 3/4: select, then scale (3 cycles total)
    // ----------------------------------------------------------------------
    signal_select #(.payload_t(sample_t), .SRC_N(OUT_SRC_N), .SEL_W(OUT_SEL_W))
        slow3_sel_inst (.clk(clk), .rst(rst), .i_src(slow_src), .i_sel(cfg.slow3_sel),
                        .o_out(slow3_smp));
    signal_select #(.payload_t(sample_t), .SRC_N(OUT_SRC_N), .SEL_W(OUT_SEL_W))
        slow4_sel_inst (.clk(clk), .rst(rst), .i_src(slow_src), .i_sel(cfg.slow4_sel),
                        .o_out(slow4_smp));

    slow_dac_scale slow3_scale_inst (.clk(clk), .rst(rst), .i_sample(slow3_smp),
                                     .o_code(o_slow3));
    slow_dac_scale slow4_scale_inst (.clk(clk), .rst(rst), .i_sample(slow4_smp),
                                     .o_code(o_slow4));

    trigger_detect trig_inst (
        .clk           (clk),
        .rst           (rst),
        .i_ext_trigger (i_ext_trigger),
        .i_trig_sel    (cfg.trig_sel),
        .o_trigger     (o_trigger)
    );

    assign o_osc_ctrl = cfg.osc_ctrl;

    // live values for readback
    assign status = '{
        in1:   i_in1,
        in2:   i_in2,
        out1:  o_out1,
        out2:  o_out2,
        osc_a: o_osc1,
        osc_b: o_osc2,
        slow3: o_slow3,
        slow4: o_slow4
    };

endmodule

`default_nettype wire

//--- hw/router_regs.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone classic slave, config regs + status readback
module router_regs (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 i_wb_cyc,
    input  wire                                 i_wb_stb,
    input  wire                                 i_wb_we,
    input  wire [router_pkg::WB_ADR_W-1:0]      i_wb_adr,
    input  wire [router_pkg::WB_DAT_W-1:0]      i_wb_dat,
    output logic [router_pkg::WB_DAT_W-1:0]     o_wb_dat,
    output logic                                o_wb_ack,
    input  wire router_pkg::route_status_t      i_status,
    output router_pkg::route_cfg_t              o_cfg
);
    import router_pkg::*;

    logic                req;       // cyc & stb
    logic                take;      // first cycle of a request
    logic                wr_en;
    logic [WB_DAT_W-1:0] rd_data;

    // sign extend a sample to bus width
    function automatic logic [WB_DAT_W-1:0] sext(input sample_t s);
        return {{(WB_DAT_W-SAMPLE_W){s[SAMPLE_W-1]}}, s};
    endfunction

    assign req   = i_wb_cyc & i_wb_stb;
    assign take  = req & ~o_wb_ack;     // no back to back ack
    assign wr_en = take & i_wb_we;

    // ----------------------------------------------------------------------
    // ack, one cycle per request
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= take;
        end
    end

    // ----------------------------------------------------------------------
    // config write, low field bits only
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_cfg <= RST_CFG;
        end else if (wr_en) begin
            case (i_wb_adr)
                ADR_SCOPE_A:   o_cfg.scope_a_sel <= i_wb_dat[SCOPE_SEL_W-1:0];
                ADR_SCOPE_B:   o_cfg.scope_b_sel <= i_wb_dat[SCOPE_SEL_W-1:0];
                ADR_OSC_CTRL:  o_cfg.osc_ctrl    <= i_wb_dat[OSC_CTRL_W-1:0];
                ADR_TRIG:      o_cfg.trig_sel    <= i_wb_dat[TRIG_SEL_W-1:0];
                ADR_OUT1_SEL:  o_cfg.out1_sel    <= i_wb_dat[OUT_SEL_W-1:0];
                ADR_OUT2_SEL:  o_cfg.out2_sel    <= i_wb_dat[OUT_SEL_W-1:0];
                ADR_SLOW3_SEL: o_cfg.slow3_sel   <= i_wb_dat[OUT_SEL_W-1:0];
                ADR_SLOW4_SEL: o_cfg.slow4_sel   <= i_wb_dat[OUT_SEL_W-1:0];
                default: ;  // read only / unmapped, dropped
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // readback mux
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_wb_adr)
            ADR_SCOPE_A:   rd_data = WB_DAT_W'(o_cfg.scope_a_sel);
            ADR_SCOPE_B:   rd_data = WB_DAT_W'(o_cfg.scope_b_sel);
            ADR_OSC_CTRL:  rd_data = WB_DAT_W'(o_cfg.osc_ctrl);
            ADR_TRIG:      rd_data = WB_DAT_W'(o_cfg.trig_sel);
            ADR_OUT1_SEL:  rd_data = WB_DAT_W'(o_cfg.out1_sel);
            ADR_OUT2_SEL:  rd_data = WB_DAT_W'(o_cfg.out2_sel);
            ADR_SLOW3_SEL: rd_data = WB_DAT_W'(o_cfg.slow3_sel);
            ADR_SLOW4_SEL: rd_data = WB_DAT_W'(o_cfg.slow4_sel);
            ADR_IN1:       rd_data = sext(i_status.in1);     // live adc
            ADR_IN2:       rd_data = sext(i_status.in2);
            ADR_OUT1:      rd_data = sext(i_status.out1);
            ADR_OUT2:      rd_data = sext(i_status.out2);
            ADR_SLOW3:     rd_data = WB_DAT_W'(i_status.slow3);
            ADR_SLOW4:     rd_data = WB_DAT_W'(i_status.slow4);
            ADR_OSCA:      rd_data = sext(i_status.osc_a);
            ADR_OSCB:      rd_data = sext(i_status.osc_b);
            default:       rd_data = '0;
        endcase
    end

    // data lines up with ack
    always_ff @(posedge clk) begin
        if (take) begin
            o_wb_dat <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/trigger_detect.sv
`timescale 1ns/1ps
`default_nettype none

// trigger source select + rising edge tick
module trigger_detect (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                i_ext_trigger,
    input  wire [router_pkg::TRIG_SEL_W-1:0]   i_trig_sel,
    output logic                               o_trigger
);
    import router_pkg::*;

    logic trig_src [TRIG_SRC_N];
    logic trig_lvl;     // selected line, one stage late
    logic trig_prev;    // previous level

    always_comb begin
        for (int i = 0; i < TRIG_SRC_N; i++) begin
            trig_src[i] = 1'b0;     // spare trigger inputs
        end
        trig_src[SRC_EXT_TRIG] = i_ext_trigger;
    end

    signal_select #(
        .payload_t (logic),
        .SRC_N     (TRIG_SRC_N),
        .SEL_W     (TRIG_SEL_W)
    ) trig_sel_inst (
        .clk   (clk),
        .rst   (rst),
        .i_src (trig_src),
        .i_sel (i_trig_sel),
        .o_out (trig_lvl)
    );

    // low -> high gives one cycle tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trig_prev <= 1'b0;
            o_trigger <= 1'b0;
        end else begin
            trig_prev <= trig_lvl;
            o_trigger <= trig_lvl & ~trig_prev;
        end
    end

endmodule

`default_nettype wire

//--- hw/slow_dac_scale.sv
`timescale 1ns/1ps
`default_nettype none

// signed sample -> 12 bit slow dac code, 2 stage pipe
module slow_dac_scale (
    input  wire                           clk,
    input  wire                           rst,
    input  wire router_pkg::sample_t      i_sample,
    output logic [router_pkg::SLOW_W-1:0] o_code
);
    import router_pkg::*;

    logic [SAMPLE_W-1:0]    biased;   // 0 .. 16383
    logic [SLOW_PROD_W-1:0] prod_d;
    logic [SLOW_PROD_W-1:0] prod_q;

    // shift to unsigned, -8192 lands on 0
    assign biased = SAMPLE_W'(i_sample + SLOW_OFFSET);
    assign prod_d = SLOW_PROD_W'(biased * SLOW_GAIN);  // max 2555748, fits 22 bits

    // ----------------------------------------------------------------------
    // stage 1: product
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod_q <= '0;
        end else begin
            prod_q <= prod_d;
        end
    end

    // ----------------------------------------------------------------------
    // stage 2: slice
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_code <= '0;
        end else begin
            o_code <= prod_q[SLOW_LSB +: SLOW_W];   // bits 21..10
        end
    end

endmodule

`default_nettype wire

//--- hw/signal_select.sv
`timescale 1ns/1ps
`default_nettype none

// registered n:1 source selector
module signal_select #(
    parameter type payload_t = logic,
    parameter int  SRC_N     = 16,
    parameter int  SEL_W     = 4
) (
    input  wire            clk,
    input  wire            rst,
    input  wire payload_t  i_src [SRC_N],
    input  wire [SEL_W-1:0] i_sel,
    output payload_t       o_out
);

    logic     sel_ok;   // select inside the source range
    payload_t picked;

    assign sel_ok = (int'(i_sel) < SRC_N);

    always_comb begin
        picked = '0;                // out of range reads zero
        if (sel_ok) begin
            picked = i_src[i_sel];
        end
    end

    // ----------------------------------------------------------------------
    // one register stage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_out <= '0;
        end else begin
            o_out <= picked;
        end
    end

endmodule

`default_nettype wire

//--- hw/router_pkg.sv
`default_nettype none

package router_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int SAMPLE_W    = 14;    // adc / dac sample
    localparam int SLOW_W      = 12;    // slow dac code
    localparam int WB_ADR_W    = 8;     // byte address
    localparam int WB_DAT_W    = 32;
    localparam int OSC_CTRL_W  = 2;     // [osc2_filt_off, osc1_filt_off]

    // source counts, select widths
    localparam int SCOPE_SRC_N = 32;
    localparam int SCOPE_SEL_W = 5;
    localparam int OUT_SRC_N   = 16;    // fast outs and slow dacs
    localparam int OUT_SEL_W   = 4;
    localparam int TRIG_SRC_N  = 8;
    localparam int TRIG_SEL_W  = 3;

    // slow dac scaling: (x + offset) * gain, keep bits lsb+11 .. lsb
    localparam int SLOW_OFFSET = 8192;  // midscale
    localparam int SLOW_GAIN   = 156;
    localparam int SLOW_LSB    = 10;
    localparam int SLOW_PROD_W = 24;

    // register map
    localparam logic [WB_ADR_W-1:0] ADR_SCOPE_A   = 8'h00;
    localparam logic [WB_ADR_W-1:0] ADR_SCOPE_B   = 8'h04;
    localparam logic [WB_ADR_W-1:0] ADR_OSC_CTRL  = 8'h08;
    localparam logic [WB_ADR_W-1:0] ADR_TRIG      = 8'h0C;
    localparam logic [WB_ADR_W-1:0] ADR_OUT1_SEL  = 8'h10;
    localparam logic [WB_ADR_W-1:0] ADR_OUT2_SEL  = 8'h14;
    localparam logic [WB_ADR_W-1:0] ADR_SLOW3_SEL = 8'h20;
    localparam logic [WB_ADR_W-1:0] ADR_SLOW4_SEL = 8'h24;
    localparam logic [WB_ADR_W-1:0] ADR_IN1       = 8'h28;  // read only from here on
    localparam logic [WB_ADR_W-1:0] ADR_IN2       = 8'h2C;
    localparam logic [WB_ADR_W-1:0] ADR_OUT1      = 8'h30;
    localparam logic [WB_ADR_W-1:0] ADR_OUT2      = 8'h34;
    localparam logic [WB_ADR_W-1:0] ADR_SLOW3     = 8'h40;
    localparam logic [WB_ADR_W-1:0] ADR_SLOW4     = 8'h44;
    localparam logic [WB_ADR_W-1:0] ADR_OSCA      = 8'h48;
    localparam logic [WB_ADR_W-1:0] ADR_OSCB      = 8'h4C;

    // reset values, all others zero
    localparam logic [SCOPE_SEL_W-1:0] RST_SCOPE_A  = 5'd1;   // in1
    localparam logic [SCOPE_SEL_W-1:0] RST_SCOPE_B  = 5'd2;   // in2
    localparam logic [OSC_CTRL_W-1:0]  RST_OSC_CTRL = 2'd3;   // both filters off

    // source indices
    localparam int SRC_MID      = 0;    // slow dac midscale-low
    localparam int SRC_IN1      = 1;
    localparam int SRC_IN2      = 2;
    localparam int SRC_EXT_TRIG = 0;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    localparam sample_t SLOW_MID_LOW = sample_t'(-SLOW_OFFSET);  // 14'h2000

    typedef struct packed {
        logic [SCOPE_SEL_W-1:0] scope_a_sel;
        logic [SCOPE_SEL_W-1:0] scope_b_sel;
        logic [OSC_CTRL_W-1:0]  osc_ctrl;
        logic [TRIG_SEL_W-1:0]  trig_sel;
        logic [OUT_SEL_W-1:0]   out1_sel;
        logic [OUT_SEL_W-1:0]   out2_sel;
        logic [OUT_SEL_W-1:0]   slow3_sel;
        logic [OUT_SEL_W-1:0]   slow4_sel;
    } route_cfg_t;

    typedef struct packed {
        sample_t             in1;
        sample_t             in2;
        sample_t             out1;
        sample_t             out2;
        sample_t             osc_a;
        sample_t             osc_b;
        logic [SLOW_W-1:0]   slow3;
        logic [SLOW_W-1:0]   slow4;
    } route_status_t;

    localparam route_cfg_t RST_CFG = '{
        scope_a_sel: RST_SCOPE_A,
        scope_b_sel: RST_SCOPE_B,
        osc_ctrl:    RST_OSC_CTRL,
        default:     '0
    };

endpackage

`default_nettype wire
